// ==== hdl/ethpipe_bus_pkg.sv ====
package ethpipe_bus_pkg;

  typedef logic [5:0]  reg_adr_t;
  typedef logic [15:0] reg_data_t;

  // Chip-enable style slave access
  typedef struct packed {
    logic      ce;
    logic      we;
    reg_adr_t  adr;
    reg_data_t dat;
    logic [1:0] sel;
  } slv_req_t;

  // Word addresses
  localparam reg_adr_t REG_CNT0     = 6'h02;
  localparam reg_adr_t REG_CNT1     = 6'h03;
  localparam reg_adr_t REG_CNT2     = 6'h04;
  localparam reg_adr_t REG_CNT3     = 6'h05;
  localparam reg_adr_t REG_STATUS   = 6'h08;
  localparam reg_adr_t REG_LEN_LO   = 6'h0a;
  localparam reg_adr_t REG_LEN_HI   = 6'h0b;
  localparam reg_adr_t REG_START_LO = 6'h10;
  localparam reg_adr_t REG_START_HI = 6'h11;
  localparam reg_adr_t REG_CUR_LO   = 6'h12;
  localparam reg_adr_t REG_CUR_HI   = 6'h13;
  localparam reg_adr_t REG_FRAMES   = 6'h1c;

  // Status bits
  localparam int unsigned ST_ENABLE   = 0;
  localparam int unsigned ST_OVERFLOW = 1;
  localparam int unsigned ST_IRQ      = 3;

  typedef logic [7:0]  status_t;
  typedef logic [15:0] frame_cnt_t;
  typedef logic [63:0] gcnt_t;

endpackage

// ==== hdl/ethpipe_dma_pkg.sv ====
package ethpipe_dma_pkg;

  // One captured word, first byte in the high half
  typedef logic [15:0] word_t;

  // Frame length in bytes
  typedef logic [10:0] frame_len_t;

  // Byte address in host memory
  typedef logic [31:0] dma_addr_t;

  // Memory-write command
  typedef struct packed {
    dma_addr_t addr;
    word_t     data;
  } mst_cmd_t;

endpackage

// ==== hdl/sync_fifo.sv ====
module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 64
) (
  input  logic             clk_125,
  input  logic             sys_rst,
  input  logic             push_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign full_o  = (count == (AW + 1)'(DEPTH));
  assign empty_o = (count == '0);
  assign dout_o  = mem[rd_ptr];

  always_ff @(posedge clk_125) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/frame_packer.sv ====
module frame_packer (
  input  logic                        clk_125,
  input  logic                        sys_rst,
  input  logic                        gmii_rx_dv_i,
  input  logic [7:0]                  gmii_rxd_i,
  output logic                        word_push_o,
  output ethpipe_dma_pkg::word_t      word_o,
  input  logic                        word_full_i,
  output logic                        len_push_o,
  output ethpipe_dma_pkg::frame_len_t len_o,
  input  logic                        len_full_i,
  output logic                        overflow_o
);

  logic                        dv_q;
  logic                        half_valid;
  logic [7:0]                  hi_byte;
  ethpipe_dma_pkg::frame_len_t byte_cnt;
  logic                        frame_end;

  // First cycle with dv low after a frame
  assign frame_end = dv_q & ~gmii_rx_dv_i;

  always_comb begin
    word_push_o = 1'b0;
    word_o      = {hi_byte, gmii_rxd_i};
    if (gmii_rx_dv_i && half_valid) begin
      word_push_o = 1'b1;
    end else if (frame_end && half_valid) begin
      // Odd length, pad low half
      word_push_o = 1'b1;
      word_o      = {hi_byte, 8'h00};
    end
  end

  assign len_push_o = frame_end;
  assign len_o      = byte_cnt;

  // Dropped pushes
  assign overflow_o = (word_push_o & word_full_i) | (len_push_o & len_full_i);

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      dv_q       <= 1'b0;
      half_valid <= 1'b0;
      byte_cnt   <= '0;
    end else begin
      dv_q <= gmii_rx_dv_i;
      if (gmii_rx_dv_i) begin
        byte_cnt   <= byte_cnt + 1'b1;
        half_valid <= ~half_valid;
      end else begin
        byte_cnt   <= '0;
        half_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (gmii_rx_dv_i && !half_valid) begin
      hi_byte <= gmii_rxd_i;
    end
  end

endmodule

// ==== hdl/dma_writer.sv ====
module dma_writer (
  input  logic                        clk_125,
  input  logic                        sys_rst,
  input  ethpipe_dma_pkg::frame_len_t len_i,
  input  logic                        len_empty_i,
  output logic                        len_pop_o,
  input  ethpipe_dma_pkg::word_t      word_i,
  input  logic                        word_empty_i,
  output logic                        word_pop_o,
  input  ethpipe_dma_pkg::dma_addr_t  buf_start_i,
  input  ethpipe_dma_pkg::dma_addr_t  buf_len_i,
  input  logic                        enable_i,
  input  logic                        load_i,
  output ethpipe_dma_pkg::dma_addr_t  cur_addr_o,
  output ethpipe_dma_pkg::mst_cmd_t   mst_cmd_o,
  output logic                        mst_valid_o,
  input  logic                        mst_ready_i,
  output logic                        frame_done_o
);

  typedef enum logic [1:0] {IDLE, HEADER, DATA, WAIT_WORD} state_t;

  state_t                      state;
  ethpipe_dma_pkg::frame_len_t words_left;
  ethpipe_dma_pkg::dma_addr_t  addr_inc;
  ethpipe_dma_pkg::dma_addr_t  buf_end;
  ethpipe_dma_pkg::dma_addr_t  next_addr;
  logic [11:0]                 len_plus;
  logic                        accept;
  logic                        need_word;

  // ----------------------------------------------------------------------
  // Ring address
  // ----------------------------------------------------------------------
  assign addr_inc  = cur_addr_o + 32'd2;
  assign buf_end   = buf_start_i + buf_len_i;
  assign next_addr = (addr_inc >= buf_end) ? buf_start_i : addr_inc;

  assign accept   = mst_valid_o & mst_ready_i;
  assign len_plus = {1'b0, len_i} + 12'd1;

  assign len_pop_o    = (state == IDLE) & enable_i & ~len_empty_i;
  assign frame_done_o = (state == DATA) & accept & (words_left == 11'd1);
  assign need_word    = (state == WAIT_WORD) |
                        (accept & ((state == HEADER) | ((state == DATA) & (words_left != 11'd1))));
  assign word_pop_o   = need_word & ~word_empty_i;

  // ----------------------------------------------------------------------
  // Command FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state       <= IDLE;
      mst_valid_o <= 1'b0;
      words_left  <= '0;
      cur_addr_o  <= buf_start_i;
    end else begin
      if (load_i) begin
        cur_addr_o <= buf_start_i;
      end else if (accept) begin
        cur_addr_o <= next_addr;
      end
      case (state)
        IDLE: begin
          if (len_pop_o) begin
            words_left  <= len_plus[11:1];
            mst_valid_o <= 1'b1;
            state       <= HEADER;
          end
        end
        HEADER, DATA: begin
          if (accept) begin
            if (state == DATA) begin
              words_left <= words_left - 1'b1;
            end
            if (frame_done_o) begin
              mst_valid_o <= 1'b0;
              state       <= IDLE;
            end else if (word_pop_o) begin
              state <= DATA;
            end else begin
              mst_valid_o <= 1'b0;
              state       <= WAIT_WORD;
            end
          end
        end
        WAIT_WORD: begin
          if (word_pop_o) begin
            mst_valid_o <= 1'b1;
            state       <= DATA;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Command payload
  always_ff @(posedge clk_125) begin
    if (len_pop_o) begin
      mst_cmd_o.addr <= cur_addr_o;
      mst_cmd_o.data <= ethpipe_dma_pkg::word_t'(len_i);
    end else if (word_pop_o) begin
      mst_cmd_o.addr <= (state == WAIT_WORD) ? cur_addr_o : next_addr;
      mst_cmd_o.data <= word_i;
    end
  end

endmodule

// ==== hdl/ethpipe_regs.sv ====
module ethpipe_regs (
  input  logic                          clk_125,
  input  logic                          sys_rst,
  input  ethpipe_bus_pkg::slv_req_t     slv_req_i,
  output ethpipe_bus_pkg::reg_data_t    slv_dat_o,
  input  ethpipe_dma_pkg::dma_addr_t    cur_addr_i,
  input  logic                          frame_done_i,
  input  logic                          overflow_i,
  output ethpipe_dma_pkg::dma_addr_t    buf_start_o,
  output ethpipe_dma_pkg::dma_addr_t    buf_len_o,
  output logic                          enable_o,
  output logic                          load_o,
  output logic                          sys_intr_o
);

  ethpipe_bus_pkg::gcnt_t      global_cnt;
  ethpipe_bus_pkg::status_t    status;
  ethpipe_bus_pkg::frame_cnt_t frame_cnt;
  ethpipe_bus_pkg::reg_data_t  rd_data;
  logic                        wr;
  logic                        rd;

  // Byte-lane merge of a write into an old value
  function automatic ethpipe_bus_pkg::reg_data_t merge(
    input ethpipe_bus_pkg::reg_data_t old_v,
    input ethpipe_bus_pkg::reg_data_t dat,
    input logic [1:0]                 sel
  );
    ethpipe_bus_pkg::reg_data_t res;
    res = old_v;
    if (sel[1]) res[15:8] = dat[15:8];
    if (sel[0]) res[7:0]  = dat[7:0];
    return res;
  endfunction

  assign wr = slv_req_i.ce & slv_req_i.we;
  assign rd = slv_req_i.ce & ~slv_req_i.we;

  assign enable_o   = status[ethpipe_bus_pkg::ST_ENABLE];
  assign sys_intr_o = status[ethpipe_bus_pkg::ST_IRQ];

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (slv_req_i.adr)
      ethpipe_bus_pkg::REG_CNT0:     rd_data = global_cnt[15:0];
      ethpipe_bus_pkg::REG_CNT1:     rd_data = global_cnt[31:16];
      ethpipe_bus_pkg::REG_CNT2:     rd_data = global_cnt[47:32];
      ethpipe_bus_pkg::REG_CNT3:     rd_data = global_cnt[63:48];
      ethpipe_bus_pkg::REG_STATUS:   rd_data = {8'h00, status};
      ethpipe_bus_pkg::REG_LEN_LO:   rd_data = buf_len_o[15:0];
      ethpipe_bus_pkg::REG_LEN_HI:   rd_data = buf_len_o[31:16];
      ethpipe_bus_pkg::REG_START_LO: rd_data = buf_start_o[15:0];
      ethpipe_bus_pkg::REG_START_HI: rd_data = buf_start_o[31:16];
      ethpipe_bus_pkg::REG_CUR_LO:   rd_data = cur_addr_i[15:0];
      ethpipe_bus_pkg::REG_CUR_HI:   rd_data = cur_addr_i[31:16];
      ethpipe_bus_pkg::REG_FRAMES:   rd_data = frame_cnt;
      default:                       rd_data = '0;
    endcase
  end

  // Free-running counter
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      global_cnt <= '0;
    end else begin
      global_cnt <= global_cnt + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Register writes and events
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      slv_dat_o   <= '0;
      status      <= '0;
      frame_cnt   <= '0;
      buf_len_o   <= 32'h0000_1000;
      buf_start_o <= 32'h1000_0000;
      load_o      <= 1'b0;
    end else begin
      load_o <= 1'b0;
      if (wr) begin
        case (slv_req_i.adr)
          ethpipe_bus_pkg::REG_STATUS: status <= slv_req_i.dat[7:0];
          ethpipe_bus_pkg::REG_LEN_LO: begin
            buf_len_o[15:0] <= merge(buf_len_o[15:0], slv_req_i.dat, slv_req_i.sel);
            load_o          <= 1'b1;
          end
          ethpipe_bus_pkg::REG_LEN_HI: begin
            buf_len_o[31:16] <= merge(buf_len_o[31:16], slv_req_i.dat, slv_req_i.sel);
            load_o           <= 1'b1;
          end
          ethpipe_bus_pkg::REG_START_LO: begin
            buf_start_o[15:0] <= merge(buf_start_o[15:0], slv_req_i.dat, slv_req_i.sel);
            load_o            <= 1'b1;
          end
          ethpipe_bus_pkg::REG_START_HI: begin
            buf_start_o[31:16] <= merge(buf_start_o[31:16], slv_req_i.dat, slv_req_i.sel);
            load_o             <= 1'b1;
          end
          default: ;
        endcase
      end
      // Hardware sets win over a clearing write
      if (overflow_i) begin
        status[ethpipe_bus_pkg::ST_OVERFLOW] <= 1'b1;
      end
      if (frame_done_i) begin
        status[ethpipe_bus_pkg::ST_IRQ] <= 1'b1;
        frame_cnt                       <= frame_cnt + 1'b1;
      end
      if (rd) begin
        slv_dat_o <= rd_data;
      end
    end
  end

endmodule

// ==== hdl/ethpipe_mid.sv ====
module ethpipe_mid #(
  parameter int DATA_DEPTH = 64,
  parameter int LEN_DEPTH  = 8
) (
  input  logic                       clk_125,
  input  logic                       sys_rst,
  input  logic                       gmii_rx_dv_i,
  input  logic [7:0]                 gmii_rxd_i,
  input  ethpipe_bus_pkg::slv_req_t  slv_req_i,
  output ethpipe_bus_pkg::reg_data_t slv_dat_o,
  output ethpipe_dma_pkg::mst_cmd_t  mst_cmd_o,
  output logic                       mst_valid_o,
  input  logic                       mst_ready_i,
  output logic                       sys_intr_o
);

  ethpipe_dma_pkg::word_t      pk_word;
  ethpipe_dma_pkg::word_t      fifo_word;
  ethpipe_dma_pkg::frame_len_t pk_len;
  ethpipe_dma_pkg::frame_len_t fifo_len;
  ethpipe_dma_pkg::dma_addr_t  buf_start;
  ethpipe_dma_pkg::dma_addr_t  buf_len;
  ethpipe_dma_pkg::dma_addr_t  cur_addr;
  logic word_push, word_full, word_pop, word_empty;
  logic len_push, len_full, len_pop, len_empty;
  logic overflow, enable, load, frame_done;

  frame_packer packer (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .gmii_rx_dv_i(gmii_rx_dv_i), .gmii_rxd_i(gmii_rxd_i),
    .word_push_o(word_push), .word_o(pk_word), .word_full_i(word_full),
    .len_push_o(len_push), .len_o(pk_len), .len_full_i(len_full),
    .overflow_o(overflow)
  );

  sync_fifo #(.WIDTH($bits(ethpipe_dma_pkg::word_t)), .DEPTH(DATA_DEPTH)) data_fifo (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .push_i(word_push), .din_i(pk_word), .pop_i(word_pop),
    .dout_o(fifo_word), .full_o(word_full), .empty_o(word_empty)
  );

  sync_fifo #(.WIDTH($bits(ethpipe_dma_pkg::frame_len_t)), .DEPTH(LEN_DEPTH)) len_fifo (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .push_i(len_push), .din_i(pk_len), .pop_i(len_pop),
    .dout_o(fifo_len), .full_o(len_full), .empty_o(len_empty)
  );

  dma_writer writer (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .len_i(fifo_len), .len_empty_i(len_empty), .len_pop_o(len_pop),
    .word_i(fifo_word), .word_empty_i(word_empty), .word_pop_o(word_pop),
    .buf_start_i(buf_start), .buf_len_i(buf_len),
    .enable_i(enable), .load_i(load), .cur_addr_o(cur_addr),
    .mst_cmd_o(mst_cmd_o), .mst_valid_o(mst_valid_o), .mst_ready_i(mst_ready_i),
    .frame_done_o(frame_done)
  );

  ethpipe_regs regs (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .slv_req_i(slv_req_i), .slv_dat_o(slv_dat_o),
    .cur_addr_i(cur_addr), .frame_done_i(frame_done), .overflow_i(overflow),
    .buf_start_o(buf_start), .buf_len_o(buf_len),
    .enable_o(enable), .load_o(load), .sys_intr_o(sys_intr_o)
  );

endmodule

// ==== tb/tb_ethpipe_mid.sv ====
module tb_ethpipe_mid;

  localparam int MAX_ENTRIES     = 128;
  localparam int CYCLES_PER_LINE = 50;

  localparam logic [31:0] OP_WRITE = 32'h1;
  localparam logic [31:0] OP_READ  = 32'h2;
  localparam logic [31:0] OP_BYTE  = 32'h3;
  localparam logic [31:0] OP_GAP   = 32'h4;
  localparam logic [31:0] OP_CMD   = 32'h5;
  localparam logic [31:0] OP_IRQ   = 32'h6;
  localparam logic [31:0] OP_COUNT = 32'h7;
  localparam logic [31:0] OP_END   = 32'hf;

  logic                       clk_125    = 1'b0;
  logic                       sys_rst    = 1'b1;
  logic                       gmii_rx_dv = 1'b0;
  logic [7:0]                 gmii_rxd   = 8'h00;
  ethpipe_bus_pkg::slv_req_t  slv_req    = '0;
  ethpipe_bus_pkg::reg_data_t slv_dat;
  ethpipe_dma_pkg::mst_cmd_t  mst_cmd;
  logic                       mst_valid;
  logic                       mst_ready  = 1'b0;
  logic                       sys_intr;

  // Three words per entry for opcode, field a and field b
  logic [31:0]               golden [3*MAX_ENTRIES];
  ethpipe_dma_pkg::mst_cmd_t exp_q [$];
  ethpipe_dma_pkg::mst_cmd_t exp_head;
  logic [31:0]               rnd_state = 32'd47;
  int                        cycles    = 0;
  int                        limit     = 0;

  ethpipe_mid #(.DATA_DEPTH(64), .LEN_DEPTH(8)) uut (
    .clk_125(clk_125), .sys_rst(sys_rst),
    .gmii_rx_dv_i(gmii_rx_dv), .gmii_rxd_i(gmii_rxd),
    .slv_req_i(slv_req), .slv_dat_o(slv_dat),
    .mst_cmd_o(mst_cmd), .mst_valid_o(mst_valid), .mst_ready_i(mst_ready),
    .sys_intr_o(sys_intr)
  );

  always #4 clk_125 = ~clk_125;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // Slave bus accesses
  // ----------------------------------------------------------------------
  task automatic bus_write(input ethpipe_bus_pkg::reg_adr_t adr,
                           input ethpipe_bus_pkg::reg_data_t dat, input logic [1:0] sel);
    @(posedge clk_125);
    slv_req <= '{ce: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: sel};
    @(posedge clk_125);
    slv_req <= '0;
  endtask

  task automatic bus_read(input ethpipe_bus_pkg::reg_adr_t adr,
                          output ethpipe_bus_pkg::reg_data_t dat);
    @(posedge clk_125);
    slv_req <= '{ce: 1'b1, we: 1'b0, adr: adr, dat: 16'h0000, sel: 2'b11};
    @(posedge clk_125);
    slv_req <= '0;
    // Data registered on the edge above
    @(negedge clk_125);
    dat = slv_dat;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(negedge clk_125);
    end
  endtask

  task automatic run_entry(input logic [31:0] op, input logic [31:0] a,
                           input logic [31:0] b);
    ethpipe_bus_pkg::reg_data_t first;
    ethpipe_bus_pkg::reg_data_t second;
    ethpipe_bus_pkg::reg_data_t delta;
    ethpipe_dma_pkg::mst_cmd_t  cmd;
    case (op)
      OP_WRITE: begin
        bus_write(a[5:0], b[15:0], a[17:16]);
      end
      OP_READ: begin
        bus_read(a[5:0], first);
        check_value($sformatf("slv_dat_o[%h]", a[5:0]), 64'(first), 64'(b[15:0]));
      end
      OP_BYTE: begin
        @(posedge clk_125);
        gmii_rx_dv <= 1'b1;
        gmii_rxd   <= a[7:0];
      end
      OP_GAP: begin
        repeat (a) begin
          @(posedge clk_125);
          gmii_rx_dv <= 1'b0;
          gmii_rxd   <= 8'h00;
        end
      end
      OP_CMD: begin
        cmd.addr = a;
        cmd.data = b[15:0];
        exp_q.push_back(cmd);
      end
      OP_IRQ: begin
        // Interrupt follows the last accepted command by one cycle
        wait_drained();
        repeat (2) @(posedge clk_125);
        @(negedge clk_125);
        check_value("sys_intr_o", 64'(sys_intr), 64'(a[0]));
      end
      OP_COUNT: begin
        bus_read(ethpipe_bus_pkg::REG_CNT0, first);
        repeat (a) @(posedge clk_125);
        bus_read(ethpipe_bus_pkg::REG_CNT0, second);
        delta = second - first;
        check_value("slv_dat_o cnt0 increase", 64'(delta), 64'(b[15:0]));
      end
      default: begin
        abort_run($sformatf("Golden file holds an unknown opcode %h", op));
      end
    endcase
  endtask

  // Random back-pressure
  always @(posedge clk_125) begin
    if (sys_rst) begin
      mst_ready <= 1'b0;
    end else begin
      mst_ready <= (rnd_state[3:2] != 2'b00);
    end
    rnd_state <= xorshift32(rnd_state);
  end

  // Accepted commands against the expected queue
  always @(negedge clk_125) begin
    if (!sys_rst && mst_valid && mst_ready) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("Unexpected command at address %h with data %h",
                            mst_cmd.addr, mst_cmd.data));
      end else begin
        exp_head = exp_q.pop_front();
        check_value("mst_cmd_o.addr", 64'(mst_cmd.addr), 64'(exp_head.addr));
        check_value("mst_cmd_o.data", 64'(mst_cmd.data), 64'(exp_head.data));
      end
    end
  end

  always @(posedge clk_125) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      abort_run($sformatf("The run timed out after %0d cycles", cycles));
    end
  end

  initial begin
    int n;
    int i;
    $readmemh("tb/ethpipe_golden.txt", golden);
    n = 0;
    while (n < MAX_ENTRIES && golden[3*n] !== OP_END) begin
      n++;
    end
    if (n == 0) begin
      abort_run("The golden file holds no entries");
    end
    limit = CYCLES_PER_LINE * n;
    repeat (3) @(posedge clk_125);
    sys_rst <= 1'b0;
    @(negedge clk_125);
    check_value("mst_valid_o", 64'(mst_valid), 64'h0);
    check_value("sys_intr_o", 64'(sys_intr), 64'h0);
    check_value("slv_dat_o", 64'(slv_dat), 64'h0);
    for (i = 0; i < n; i++) begin
      run_entry(golden[3*i], golden[3*i+1], golden[3*i+2]);
    end
    if (exp_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run("Expected commands were never issued");
    end
  end

endmodule

// ==== tb/ethpipe_golden.txt ====
// op a b. 1 write {sel[17:16],adr} dat, 2 read adr expect, 3 gmii byte, 4 gap cycles
// 5 expect cmd addr data, 6 expect irq level, 7 cnt0 reads idle-cycles delta, f end
2 8 0
2 a 1000
1 1000a abcd
2 a 10cd
1 2000a 20ff
2 a 20cd
1 3000a 0100
2 b 0
2 3f 0
1 30011 2000
1 20010 12ff
2 10 1200
2 11 2000
2 12 1200
2 13 2000
1 30008 1
2 8 1
5 20001200 3
5 20001202 1122
5 20001204 3300
3 11 0
3 22 0
3 33 0
4 2 0
5 20001206 4
5 20001208 a1b2
5 2000120a c3d4
3 a1 0
3 b2 0
3 c3 0
3 d4 0
4 2 0
6 1 0
2 1c 2
2 12 120c
1 30008 1
6 0 0
1 3000a 4
5 20001200 3
5 20001202 5a6b
5 20001200 7c00
3 5a 0
3 6b 0
3 7c 0
4 2 0
6 1 0
2 8 9
2 12 1202
2 1c 3
1 30010 1400
2 10 1400
2 12 1400
2 13 2000
7 3 5
f 0 0

// ==== list.f ====
hdl/ethpipe_bus_pkg.sv
hdl/ethpipe_dma_pkg.sv
hdl/sync_fifo.sv
hdl/frame_packer.sv
hdl/dma_writer.sv
hdl/ethpipe_regs.sv
hdl/ethpipe_mid.sv
tb/tb_ethpipe_mid.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ethpipe_mid
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulator's exit status is the pass or fail result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
